/* bench/lcd_game_stim.txt */
# kinds: R wait ready, N obj_row, C char_row, W rs data, H hit, Q end
# arguments in hex, row 1 is the top row and 0 the bottom row
R
W 0 01
W 0 0C
W 0 06
W 0 80
W 1 20
W 0 C0
W 1 06
H 0
N 1
R
W 0 8F
W 1 00
W 0 C1
W 1 20
H 0
N 0
N 0
N 0
N 0
N 0
N 0
N 0
N 0
N 0
N 0
N 0
N 0
N 0
C 1
R
W 0 C0
W 1 20
W 0 80
W 1 06
H 0
N 0
R
W 0 81
W 1 00
W 0 82
W 1 20
H 1
C 0
N 1
R
W 0 80
W 1 20
W 0 C0
W 1 06
H 0
N 0
R
W 0 CF
W 1 00
W 0 81
W 1 20
H 0
N 1
N 1
N 1
N 1
N 1
N 1
N 1
N 1
N 1
N 1
N 1
N 1
N 1
C 1
R
N 1
R
W 0 C1
W 1 00
W 0 C2
W 1 20
H 0
Q

/* sim.f */
+incdir+hdl
hdl/lcd_pkg.sv
hdl/lcd_bus_writer.sv
hdl/frame_sequencer.sv
hdl/scene_state.sv
hdl/lcd_game_top.sv
bench/lcd_game_tb.sv

/* bench/lcd_game_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module lcd_game_tb;

    localparam int CLK_PERIOD    = 4;
    localparam int DRIVE_DELAY   = 1;     // inputs change this long after the rising edge
    localparam int RECORD_CYCLES = 40;    // watchdog budget per stim record
    localparam STIM_FILE = "bench/lcd_game_stim.txt";

    logic               clk;
    logic               rst;
    logic               next;
    logic               char_row;
    logic               obj_row;
    lcd_pkg::lcd_pins_t lcd;
    logic               ready;
    logic               hit;
    logic               lcd_en;

    // one stim record per non-comment line
    logic [7:0] rec_kind[$];
    int         rec_a[$];
    int         rec_b[$];
    logic       loaded = 1'b0;
    logic       saw_end = 1'b0;

    logic [8:0] wr_q[$];                  // {rs, data} of every enable pulse
    int         wr_count = 0;
    int         expected_count = 7;       // power-up list first
    int         wr_idx = 0;
    int         action_no = 0;
    string      action_name = "init";
    logic       char_pending = 1'b0;      // char_row changed but not yet clocked

    lcd_game_top dut0 (
        .clk      (clk),
        .rst      (rst),
        .next     (next),
        .char_row (char_row),
        .obj_row  (obj_row),
        .lcd      (lcd),
        .ready    (ready),
        .hit      (hit)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // LCD write monitor
    assign lcd_en = lcd.en;

    always @(posedge lcd_en) begin
        wr_q.push_back({lcd.rs, lcd.data});
        wr_count = wr_count + 1;
    end

    task automatic stop_on_error;
        $display("Done: errors found");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic fail_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        $display("[FAIL] %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        stop_on_error();
    endtask

    task automatic fail_text(input string what);
        $display("%s", what);
        stop_on_error();
    endtask

    task automatic load_stim;
        int fd;
        int c;
        int a;
        int b;
        int n;
        int n_args;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            fail_text("cannot open the stimulus file bench/lcd_game_stim.txt");
        end
        c = $fgetc(fd);
        while (c != -1) begin
            if (c == "#") begin
                while (c != "\n" && c != -1) begin
                    c = $fgetc(fd);
                end
            end else if (c != " " && c != "\n" && c != "\r" && c != "\t") begin
                a      = 0;
                b      = 0;
                n      = 0;
                n_args = 0;
                if (c == "W") begin
                    n_args = 2;
                    n = $fscanf(fd, "%h %h", a, b);
                end else if (c == "N" || c == "C" || c == "H") begin
                    n_args = 1;
                    n = $fscanf(fd, "%h", a);
                end
                if (n != n_args) begin
                    fail_text($sformatf("stimulus record %c has missing or bad arguments",
                                        c[7:0]));
                end
                rec_kind.push_back(c[7:0]);
                rec_a.push_back(a);
                rec_b.push_back(b);
            end
            c = $fgetc(fd);
        end
        $fclose(fd);
    endtask

    task automatic wait_ready;
        while (!ready) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    // every action after power-up emits four writes
    task automatic start_action(input string name);
        wr_q.delete();
        wr_count       = 0;
        wr_idx         = 0;
        expected_count = 4;
        action_no      = action_no + 1;
        action_name    = $sformatf("action %0d %s", action_no, name);
    endtask

    task automatic apply_char_move(input logic row);
        wait_ready();
        start_action("char move");
        char_row     = row;
        char_pending = 1'b1;
    endtask

    task automatic apply_step(input logic row);
        wait_ready();
        if (char_pending) begin
            action_name = $sformatf("action %0d char move with next", action_no);
        end else begin
            start_action("step");
        end
        next    = 1'b1;
        obj_row = row;
        @(posedge clk);
        #DRIVE_DELAY;
        next         = 1'b0;
        char_pending = 1'b0;
    endtask

    // takes at least one edge so a pending char_row change goes first
    task automatic finish_action;
        @(posedge clk);
        #DRIVE_DELAY;
        wait_ready();
        char_pending = 1'b0;
        assert (wr_count == expected_count)
            else fail_value({action_name, " write count"}, expected_count, wr_count);
    endtask

    task automatic run_record(input int i);
        logic [7:0] kind;
        logic [8:0] got;
        logic [8:0] exp_wr;
        int         a;
        int         b;
        kind = rec_kind[i];
        a    = rec_a[i];
        b    = rec_b[i];
        case (kind)
            "R": finish_action();
            "N": apply_step(a[0]);
            "C": apply_char_move(a[0]);
            "W": begin
                exp_wr = {a[0], b[7:0]};
                wr_idx = wr_idx + 1;
                assert (wr_q.size() > 0)
                    else fail_text($sformatf("%s: write %0d expected, none seen on the LCD",
                                             action_name, wr_idx));
                got = wr_q.pop_front();
                assert (got === exp_wr)
                    else fail_value($sformatf("%s write %0d", action_name, wr_idx),
                                    exp_wr, got);
            end
            "H": begin
                assert (hit === a[0]) else fail_value({action_name, " hit"}, a[0], hit);
            end
            "Q": saw_end = 1'b1;
            default: fail_text($sformatf("unknown record kind %c in the stimulus file", kind));
        endcase
    endtask

    initial begin
        int timeout_ns;
        wait (loaded);
        timeout_ns = rec_kind.size() * RECORD_CYCLES * CLK_PERIOD;
        #(timeout_ns);
        fail_text("timeout: the DUT did not get through the stimulus in time");
    end

    initial begin
        int i;
        next     = 1'b0;
        char_row = 1'b0;   // matches the character row after reset
        obj_row  = 1'b0;
        rst      = 1'b1;
        load_stim();
        loaded = 1'b1;
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        assert (ready === 1'b0) else fail_value("reset ready", 0, ready);
        assert (hit === 1'b0) else fail_value("reset hit", 0, hit);
        for (i = 0; i < rec_kind.size() && !saw_end; i++) begin
            run_record(i);
        end
        if (saw_end) begin
            $display("Done: no errors");
            $finish;
        end else begin
            fail_text("the stimulus file has no end record");
        end
    end

endmodule

`default_nettype wire

/* hdl/lcd_game_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lcd_game_top (
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire logic         next,      // advance the obstacle one column
    input  wire logic         char_row,  // 1 = top row
    input  wire logic         obj_row,   // row used when the obstacle re-enters
    output lcd_pkg::lcd_pins_t lcd,
    output logic              ready,
    output logic              hit
);

    // scene commands
    lcd_pkg::scene_cmd_t cmd;
    logic                cmd_stb;
    logic                cmd_ack;

    // single LCD writes
    lcd_pkg::lcd_req_t   req;
    logic                req_stb;
    logic                req_ack;

    scene_state u_scene (
        .clk      (clk),
        .rst      (rst),
        .next     (next),
        .char_row (char_row),
        .obj_row  (obj_row),
        .cmd_ack  (cmd_ack),
        .cmd      (cmd),
        .cmd_stb  (cmd_stb),
        .ready    (ready),
        .hit      (hit)
    );

    frame_sequencer u_seq (
        .clk      (clk),
        .rst      (rst),
        .cmd      (cmd),
        .cmd_stb  (cmd_stb),
        .req_ack  (req_ack),
        .cmd_ack  (cmd_ack),
        .req      (req),
        .req_stb  (req_stb)
    );

    lcd_bus_writer u_writer (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .req_stb  (req_stb),
        .req_ack  (req_ack),
        .lcd      (lcd)
    );

endmodule

`default_nettype wire

/* hdl/scene_state.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lcd_game_params.svh"

module scene_state (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          next,
    input  wire logic          char_row,   // 1 = top
    input  wire logic          obj_row,    // row for the next re-entry
    input  wire logic          cmd_ack,
    output lcd_pkg::scene_cmd_t cmd,
    output logic               cmd_stb,
    output logic               ready,
    output logic               hit
);

    logic [`LCD_COL_W-1:0] obj_col;
    logic                  obj_row_q;
    logic                  char_row_q;

    logic [`LCD_COL_W-1:0] step_col;
    logic                  step_row;
    logic                  wrap;

    // obstacle position after one step
    always_comb begin
        wrap     = (obj_col == `OBJ_HIT_COL);
        step_col = wrap ? `LCD_COL_W'(`LCD_COLS - 1) : obj_col - 1'b1;
        step_row = wrap ? obj_row : obj_row_q;   // row is only sampled on re-entry
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // obstacle parked on the bottom row at the hit column,
            // so the first step wraps in at column 15
            obj_col       <= `OBJ_HIT_COL;
            obj_row_q     <= 1'b0;
            char_row_q    <= 1'b0;
            ready         <= 1'b0;
            hit           <= 1'b0;
            cmd_stb       <= 1'b1;      // power-up sequence goes out right away
            cmd.op        <= lcd_pkg::OP_INIT;
            cmd.char_row  <= 1'b0;
            cmd.obj_row   <= 1'b0;
            cmd.obj_col   <= `OBJ_HIT_COL;
            cmd.erase_row <= 1'b0;
            cmd.erase_col <= `OBJ_HIT_COL;
        end else if (cmd_stb) begin
            if (cmd_ack) begin
                cmd_stb <= 1'b0;
                ready   <= 1'b1;
            end
        end else if (ready) begin
            if (char_row != char_row_q) begin
                // a move beats a pending step
                char_row_q    <= char_row;
                hit           <= 1'b0;
                ready         <= 1'b0;
                cmd_stb       <= 1'b1;
                cmd.op        <= lcd_pkg::OP_CHAR;
                cmd.char_row  <= char_row;
                cmd.obj_row   <= obj_row_q;
                cmd.obj_col   <= obj_col;
                cmd.erase_row <= obj_row_q;
                cmd.erase_col <= obj_col;
            end else if (next) begin
                obj_col       <= step_col;
                obj_row_q     <= step_row;
                hit           <= (step_col == `OBJ_HIT_COL) && (step_row == char_row_q);
                ready         <= 1'b0;
                cmd_stb       <= 1'b1;
                cmd.op        <= lcd_pkg::OP_STEP;
                cmd.char_row  <= char_row_q;
                cmd.obj_row   <= step_row;
                cmd.obj_col   <= step_col;
                cmd.erase_row <= obj_row_q;   // old cell gets blanked
                cmd.erase_col <= obj_col;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/frame_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lcd_game_params.svh"

module frame_sequencer (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire lcd_pkg::scene_cmd_t cmd,
    input  wire logic                cmd_stb,
    input  wire logic                req_ack,
    output logic                     cmd_ack,
    output lcd_pkg::lcd_req_t        req,
    output logic                     req_stb
);

    // write list positions, OP_CHAR enters the init list at CHAR_FIRST
    localparam logic [2:0] CHAR_FIRST = 3'd3;
    localparam logic [2:0] INIT_LAST  = 3'd6;
    localparam logic [2:0] STEP_LAST  = 3'd3;

    lcd_pkg::seq_state_e state;
    lcd_pkg::scene_cmd_t cmd_q;
    logic [2:0]          idx;
    logic [2:0]          last_idx;

    // set-address instruction for one cell
    function automatic logic [`LCD_DATA_W-1:0] cell_addr(
        input logic                  row,
        input logic [`LCD_COL_W-1:0] col
    );
        logic [`LCD_DATA_W-1:0] base;
        base = row ? `LCD_ROW_TOP_BASE : `LCD_ROW_BOT_BASE;
        return `LCD_CMD_SET_ADDR | base | `LCD_DATA_W'(col);
    endfunction

    assign last_idx = (cmd_q.op == lcd_pkg::OP_STEP) ? STEP_LAST : INIT_LAST;
    assign req_stb  = (state == lcd_pkg::SEQ_RUN);

    // current write, picked from the latched command and the index
    always_comb begin
        req.rs   = 1'b0;
        req.data = '0;
        if (cmd_q.op == lcd_pkg::OP_STEP) begin
            case (idx)
                3'd0: req.data = cell_addr(cmd_q.obj_row, cmd_q.obj_col);
                3'd1: begin
                    req.rs   = 1'b1;
                    req.data = `GLYPH_OBJ;
                end
                3'd2: req.data = cell_addr(cmd_q.erase_row, cmd_q.erase_col);
                default: begin
                    req.rs   = 1'b1;
                    req.data = `GLYPH_BLANK;
                end
            endcase
        end else begin
            case (idx)
                3'd0: req.data = `LCD_CMD_CLEAR;
                3'd1: req.data = `LCD_CMD_DISP_ON;
                3'd2: req.data = `LCD_CMD_ENTRY;
                3'd3: req.data = cell_addr(~cmd_q.char_row, '0);  // row without the character
                3'd4: begin
                    req.rs   = 1'b1;
                    req.data = `GLYPH_BLANK;
                end
                3'd5: req.data = cell_addr(cmd_q.char_row, '0);
                default: begin
                    req.rs   = 1'b1;
                    req.data = `GLYPH_CHAR;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == lcd_pkg::SEQ_IDLE && cmd_stb) begin
            cmd_q <= cmd;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= lcd_pkg::SEQ_IDLE;
            idx     <= '0;
            cmd_ack <= 1'b0;
        end else begin
            case (state)
                lcd_pkg::SEQ_IDLE: begin
                    cmd_ack <= 1'b0;
                    if (cmd_stb) begin
                        idx   <= (cmd.op == lcd_pkg::OP_CHAR) ? CHAR_FIRST : 3'd0;
                        state <= lcd_pkg::SEQ_RUN;
                    end
                end
                lcd_pkg::SEQ_RUN: begin
                    // request is held until the writer acks it
                    if (req_ack) begin
                        if (idx == last_idx) begin
                            cmd_ack <= 1'b1;
                            state   <= lcd_pkg::SEQ_DONE;
                        end else begin
                            idx <= idx + 3'd1;
                        end
                    end
                end
                lcd_pkg::SEQ_DONE: begin
                    // master drops cmd_stb while we sit here
                    cmd_ack <= 1'b0;
                    idx     <= '0;
                    state   <= lcd_pkg::SEQ_IDLE;
                end
                default: begin
                    cmd_ack <= 1'b0;
                    state   <= lcd_pkg::SEQ_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/lcd_bus_writer.sv */
`timescale 1ns/1ps
`default_nettype none

module lcd_bus_writer (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire lcd_pkg::lcd_req_t req,
    input  wire logic             req_stb,
    output logic                  req_ack,
    output lcd_pkg::lcd_pins_t    lcd
);

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_PULSE,     // en is high
        WR_RELEASE    // en low again, ack to the master
    } wr_state_e;

    wr_state_e state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= WR_IDLE;
            lcd     <= '0;
            req_ack <= 1'b0;
        end else begin
            case (state)
                WR_IDLE: begin
                    req_ack <= 1'b0;
                    if (req_stb) begin
                        // data and rs are set up together with the rising en
                        lcd.data <= req.data;
                        lcd.rs   <= req.rs;
                        lcd.en   <= 1'b1;
                        state    <= WR_PULSE;
                    end
                end
                WR_PULSE: begin
                    lcd.en  <= 1'b0;  // falling edge latches the byte in the LCD
                    req_ack <= 1'b1;
                    state   <= WR_RELEASE;
                end
                WR_RELEASE: begin
                    // master moves to its next request during this cycle
                    req_ack <= 1'b0;
                    state   <= WR_IDLE;
                end
                default: begin
                    req_ack <= 1'b0;
                    lcd.en  <= 1'b0;
                    state   <= WR_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/lcd_pkg.sv */
`default_nettype none

`include "lcd_game_params.svh"

package lcd_pkg;

    // one write on the LCD bus
    typedef struct packed {
        logic                   rs;     // 0 = instruction, 1 = data
        logic [`LCD_DATA_W-1:0] data;
    } lcd_req_t;

    // physical LCD pins, rw is tied to write on the board
    typedef struct packed {
        logic [`LCD_DATA_W-1:0] data;
        logic                   rs;
        logic                   en;
    } lcd_pins_t;

    typedef enum logic [1:0] {
        OP_INIT,    // power-up commands, then the character
        OP_CHAR,    // redraw the character in column 0
        OP_STEP     // move the obstacle one cell
    } scene_op_e;

    // row bits are 1 for the top row, 0 for the bottom row
    typedef struct packed {
        scene_op_e             op;
        logic                  char_row;
        logic                  obj_row;
        logic [`LCD_COL_W-1:0] obj_col;
        logic                  erase_row;
        logic [`LCD_COL_W-1:0] erase_col;
    } scene_cmd_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_RUN,    // stepping through the write list
        SEQ_DONE    // cmd_ack cycle
    } seq_state_e;

endpackage

`default_nettype wire

/* hdl/lcd_game_params.svh */
`ifndef LCD_GAME_PARAMS_SVH
`define LCD_GAME_PARAMS_SVH

// display geometry
`define LCD_DATA_W          8
`define LCD_COLS            16
`define LCD_COL_W           4

// DDRAM base address of each row
`define LCD_ROW_TOP_BASE    8'h00
`define LCD_ROW_BOT_BASE    8'h40

// HD44780 instruction codes
`define LCD_CMD_SET_ADDR    8'h80   // or'ed with the DDRAM address
`define LCD_CMD_CLEAR       8'h01
`define LCD_CMD_DISP_ON     8'h0C   // display on, cursor off, blink off
`define LCD_CMD_ENTRY       8'h06   // increment, no display shift

// character codes, the obstacle and the player live in CGRAM
`define GLYPH_OBJ           8'h00
`define GLYPH_CHAR          8'h06
`define GLYPH_BLANK         8'h20   // ascii space

// obstacle turns around here, and a hit is checked here
`define OBJ_HIT_COL         4'd1

`endif
